//--- tpu_pkg.sv
package tpu_pkg;

    // array geometry
    localparam int ARRAY_DIM = 4;

    // element and sum widths
    localparam int ELEM_W = 8;
    localparam int ACC_W  = 32;

    // bus widths derived from the geometry
    localparam int DIM_W   = 8;
    localparam int INDEX_W = 16;
    localparam int LANE_W  = ARRAY_DIM * ELEM_W;
    localparam int C_ROW_W = ARRAY_DIM * ACC_W;
    localparam int GRID_W  = ARRAY_DIM * C_ROW_W;

    // read latency 1, skew 3, mesh travel 3, accumulate 1
    localparam int SETTLE_CYCLES = 8;

    typedef logic [DIM_W-1:0]   dim_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [ELEM_W-1:0]  elem_t;
    typedef logic [ACC_W-1:0]   acc_t;

    // one A or B buffer word, lane 0 in the top byte
    typedef logic [LANE_W-1:0]  lane_word_t;

    // one C buffer word, column 0 in the top 32 bits
    typedef logic [C_ROW_W-1:0] c_row_t;

    // all sixteen sums, row 0 in the top 128 bits
    typedef logic [GRID_W-1:0]  psum_grid_t;

    // rows to drain, 1 to ARRAY_DIM
    typedef logic [$clog2(ARRAY_DIM):0] row_count_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_SETTLE,
        SEQ_DRAIN
    } seq_state_t;

endpackage

//--- drain_if.sv
`timescale 1ns/1ps

// four-phase handshake between the sequencer and the drain
interface drain_if;

    // request for one tile, held until ack
    logic req;

    // number of C rows in this tile
    tpu_pkg::row_count_t rows;

    // C address of the first row
    tpu_pkg::index_t c_base;

    // raised once all rows are written, dropped after req falls
    logic ack;

    // sequencer side
    modport seq (
        output req,
        output rows,
        output c_base,
        input  ack
    );

    // drain side
    modport drain (
        input  req,
        input  rows,
        input  c_base,
        output ack
    );

endinterface

//--- mac_pe.sv
`timescale 1ns/1ps

module mac_pe (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           clear,
    input  tpu_pkg::elem_t west,
    input  tpu_pkg::elem_t north,
    output tpu_pkg::elem_t east,
    output tpu_pkg::elem_t south,
    output tpu_pkg::acc_t  psum
);

    logic [2*tpu_pkg::ELEM_W-1:0] product;

    // full 16-bit product, widened before the add
    assign product = west * north;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum  <= '0;
            east  <= '0;
            south <= '0;
        end else begin
            // zero operands leave the sum as it is
            if (clear) begin
                psum <= '0;
            end else begin
                psum <= psum + tpu_pkg::acc_t'(product);
            end
            // operands move one PE per cycle
            east  <= west;
            south <= north;
        end
    end

endmodule

//--- pe_array.sv
`timescale 1ns/1ps

module pe_array (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,
    input  tpu_pkg::lane_word_t west_lanes,
    input  tpu_pkg::lane_word_t north_lanes,
    output tpu_pkg::psum_grid_t psum_grid
);

    tpu_pkg::elem_t east_out  [tpu_pkg::ARRAY_DIM][tpu_pkg::ARRAY_DIM];
    tpu_pkg::elem_t south_out [tpu_pkg::ARRAY_DIM][tpu_pkg::ARRAY_DIM];
    tpu_pkg::acc_t  psum_out  [tpu_pkg::ARRAY_DIM][tpu_pkg::ARRAY_DIM];

    for (genvar r = 0; r < tpu_pkg::ARRAY_DIM; r++) begin : g_row
        for (genvar c = 0; c < tpu_pkg::ARRAY_DIM; c++) begin : g_col
            tpu_pkg::elem_t west_in;
            tpu_pkg::elem_t north_in;

            // left column takes row lane r
            if (c == 0) begin : g_west_edge
                assign west_in =
                    west_lanes[tpu_pkg::ELEM_W*(tpu_pkg::ARRAY_DIM-1-r) +: tpu_pkg::ELEM_W];
            end else begin : g_west_link
                assign west_in = east_out[r][c-1];
            end

            // top row takes column lane c
            if (r == 0) begin : g_north_edge
                assign north_in =
                    north_lanes[tpu_pkg::ELEM_W*(tpu_pkg::ARRAY_DIM-1-c) +: tpu_pkg::ELEM_W];
            end else begin : g_north_link
                assign north_in = south_out[r-1][c];
            end

            mac_pe u_pe (
                .clk   (clk),
                .rst_n (rst_n),
                .clear (clear),
                .west  (west_in),
                .north (north_in),
                .east  (east_out[r][c]),
                .south (south_out[r][c]),
                .psum  (psum_out[r][c])
            );

            // PE (0,0) lands in the top 32 bits
            assign psum_grid[tpu_pkg::ACC_W*(tpu_pkg::ARRAY_DIM*tpu_pkg::ARRAY_DIM-1
                             - (r*tpu_pkg::ARRAY_DIM + c)) +: tpu_pkg::ACC_W] = psum_out[r][c];
        end
    end

endmodule

//--- operand_skewer.sv
`timescale 1ns/1ps

module operand_skewer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                feed_en,
    input  tpu_pkg::lane_word_t a_word,
    input  tpu_pkg::lane_word_t b_word,
    output tpu_pkg::lane_word_t west_lanes,
    output tpu_pkg::lane_word_t north_lanes
);

    // enable aligned with the buffer read data
    logic                feed_d;
    tpu_pkg::lane_word_t a_gate;
    tpu_pkg::lane_word_t b_gate;

    // whole words shifted, lane i taken from stage i
    tpu_pkg::lane_word_t a_dly [1:tpu_pkg::ARRAY_DIM-1];
    tpu_pkg::lane_word_t b_dly [1:tpu_pkg::ARRAY_DIM-1];

    // zeros between tiles keep the sums unchanged
    assign a_gate = feed_d ? a_word : '0;
    assign b_gate = feed_d ? b_word : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            feed_d <= 1'b0;
            for (int s = 1; s < tpu_pkg::ARRAY_DIM; s++) begin
                a_dly[s] <= '0;
                b_dly[s] <= '0;
            end
        end else begin
            feed_d   <= feed_en;
            a_dly[1] <= a_gate;
            b_dly[1] <= b_gate;
            for (int s = 2; s < tpu_pkg::ARRAY_DIM; s++) begin
                a_dly[s] <= a_dly[s-1];
                b_dly[s] <= b_dly[s-1];
            end
        end
    end

    // lane 0 sits in the top byte
    for (genvar i = 0; i < tpu_pkg::ARRAY_DIM; i++) begin : g_lane
        if (i == 0) begin : g_direct
            assign west_lanes[tpu_pkg::ELEM_W*(tpu_pkg::ARRAY_DIM-1-i) +: tpu_pkg::ELEM_W] =
                a_gate[tpu_pkg::ELEM_W*(tpu_pkg::ARRAY_DIM-1-i) +: tpu_pkg::ELEM_W];
            assign north_lanes[tpu_pkg::ELEM_W*(tpu_pkg::ARRAY_DIM-1-i) +: tpu_pkg::ELEM_W] =
                b_gate[tpu_pkg::ELEM_W*(tpu_pkg::ARRAY_DIM-1-i) +: tpu_pkg::ELEM_W];
        end else begin : g_delayed
            assign west_lanes[tpu_pkg::ELEM_W*(tpu_pkg::ARRAY_DIM-1-i) +: tpu_pkg::ELEM_W] =
                a_dly[i][tpu_pkg::ELEM_W*(tpu_pkg::ARRAY_DIM-1-i) +: tpu_pkg::ELEM_W];
            assign north_lanes[tpu_pkg::ELEM_W*(tpu_pkg::ARRAY_DIM-1-i) +: tpu_pkg::ELEM_W] =
                b_dly[i][tpu_pkg::ELEM_W*(tpu_pkg::ARRAY_DIM-1-i) +: tpu_pkg::ELEM_W];
        end
    end

endmodule

//--- result_drain.sv
`timescale 1ns/1ps

module result_drain (
    input  logic                clk,
    input  logic                rst_n,
    input  tpu_pkg::psum_grid_t psum_grid,
    output logic                c_wr_en,
    output tpu_pkg::index_t     c_index,
    output tpu_pkg::c_row_t     c_data,
    drain_if.drain              drn
);

    // high on each cycle that writes one C row
    logic                active;
    tpu_pkg::row_count_t row;
    logic                last_row;

    assign last_row = (row == drn.rows - tpu_pkg::row_count_t'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            row     <= '0;
            drn.ack <= 1'b0;
        end else if (active) begin
            if (last_row) begin
                active  <= 1'b0;
                row     <= '0;
                // ack follows the last write by one cycle
                drn.ack <= 1'b1;
            end else begin
                row <= row + tpu_pkg::row_count_t'(1);
            end
        end else if (drn.ack) begin
            // hold ack until the sequencer lets go of req
            if (!drn.req) begin
                drn.ack <= 1'b0;
            end
        end else if (drn.req) begin
            active <= 1'b1;
            row    <= '0;
        end
    end

    assign c_wr_en = active;
    assign c_index = drn.c_base + tpu_pkg::index_t'(row);

    // grid row 0 is the top slice
    assign c_data = psum_grid[tpu_pkg::C_ROW_W*(tpu_pkg::ARRAY_DIM-1-int'(row))
                              +: tpu_pkg::C_ROW_W];

endmodule

//--- tile_sequencer.sv
`timescale 1ns/1ps

module tile_sequencer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  tpu_pkg::dim_t   K,
    input  tpu_pkg::dim_t   M,
    input  tpu_pkg::dim_t   N,
    output logic            busy,
    output tpu_pkg::index_t a_index,
    output tpu_pkg::index_t b_index,
    output logic            feed_en,
    output logic            clear,
    drain_if.seq            drn
);

    tpu_pkg::seq_state_t state;

    // job dimensions, held for the whole job
    tpu_pkg::dim_t k_dim;
    tpu_pkg::dim_t m_dim;
    tpu_pkg::dim_t n_dim;

    // fetch counter in LOAD, reused as settle counter
    tpu_pkg::dim_t step;
    tpu_pkg::dim_t m_blk;
    tpu_pkg::dim_t n_blk;

    tpu_pkg::dim_t m_rem;
    tpu_pkg::dim_t m_blocks;
    tpu_pkg::dim_t n_blocks;
    logic          last_m;
    logic          last_n;
    logic          load_done;
    logic          settle_done;
    tpu_pkg::row_count_t tile_rows;

    // ceil(M/4) and ceil(N/4)
    assign m_rem    = m_dim % tpu_pkg::dim_t'(tpu_pkg::ARRAY_DIM);
    assign m_blocks = m_dim / tpu_pkg::dim_t'(tpu_pkg::ARRAY_DIM)
                    + tpu_pkg::dim_t'(m_rem != '0);
    assign n_blocks = n_dim / tpu_pkg::dim_t'(tpu_pkg::ARRAY_DIM)
                    + tpu_pkg::dim_t'((n_dim % tpu_pkg::dim_t'(tpu_pkg::ARRAY_DIM)) != '0);

    assign last_m      = (m_blk == m_blocks - tpu_pkg::dim_t'(1));
    assign last_n      = (n_blk == n_blocks - tpu_pkg::dim_t'(1));
    assign load_done   = (step == k_dim - tpu_pkg::dim_t'(1));
    assign settle_done = (step == tpu_pkg::dim_t'(tpu_pkg::SETTLE_CYCLES - 1));

    // last M block is short when M is not a multiple of 4
    assign tile_rows = (last_m && m_rem != '0) ? tpu_pkg::row_count_t'(m_rem)
                                               : tpu_pkg::row_count_t'(tpu_pkg::ARRAY_DIM);

    assign feed_en = (state == tpu_pkg::SEQ_LOAD);
    // first LOAD cycle, before any operand reaches the mesh
    assign clear   = feed_en && (step == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= tpu_pkg::SEQ_IDLE;
            busy       <= 1'b0;
            k_dim      <= '0;
            m_dim      <= '0;
            n_dim      <= '0;
            step       <= '0;
            m_blk      <= '0;
            n_blk      <= '0;
            a_index    <= '0;
            b_index    <= '0;
            drn.req    <= 1'b0;
            drn.rows   <= '0;
            drn.c_base <= '0;
        end else begin
            case (state)
                tpu_pkg::SEQ_IDLE: begin
                    if (in_valid) begin
                        k_dim      <= K;
                        m_dim      <= M;
                        n_dim      <= N;
                        busy       <= 1'b1;
                        step       <= '0;
                        m_blk      <= '0;
                        n_blk      <= '0;
                        a_index    <= '0;
                        b_index    <= '0;
                        drn.c_base <= '0;
                        state      <= tpu_pkg::SEQ_LOAD;
                    end
                end
                tpu_pkg::SEQ_LOAD: begin
                    // ends at (m+1)K and (n+1)K
                    a_index <= a_index + tpu_pkg::index_t'(1);
                    b_index <= b_index + tpu_pkg::index_t'(1);
                    if (load_done) begin
                        step  <= '0;
                        state <= tpu_pkg::SEQ_SETTLE;
                    end else begin
                        step <= step + tpu_pkg::dim_t'(1);
                    end
                end
                tpu_pkg::SEQ_SETTLE: begin
                    if (!settle_done) begin
                        step <= step + tpu_pkg::dim_t'(1);
                    end else if (!drn.ack) begin
                        // previous handshake fully closed
                        drn.req  <= 1'b1;
                        drn.rows <= tile_rows;
                        state    <= tpu_pkg::SEQ_DRAIN;
                    end
                end
                tpu_pkg::SEQ_DRAIN: begin
                    if (drn.ack) begin
                        drn.req    <= 1'b0;
                        step       <= '0;
                        // n*M + 4m walks on by the rows just written
                        drn.c_base <= drn.c_base + tpu_pkg::index_t'(drn.rows);
                        if (!last_m) begin
                            m_blk   <= m_blk + tpu_pkg::dim_t'(1);
                            b_index <= b_index - tpu_pkg::index_t'(k_dim);
                            state   <= tpu_pkg::SEQ_LOAD;
                        end else if (!last_n) begin
                            m_blk   <= '0;
                            n_blk   <= n_blk + tpu_pkg::dim_t'(1);
                            a_index <= '0;
                            state   <= tpu_pkg::SEQ_LOAD;
                        end else begin
                            busy    <= 1'b0;
                            a_index <= '0;
                            b_index <= '0;
                            state   <= tpu_pkg::SEQ_IDLE;
                        end
                    end
                end
                default: state <= tpu_pkg::SEQ_IDLE;
            endcase
        end
    end

endmodule

//--- tpu_top.sv
`timescale 1ns/1ps

module tpu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  tpu_pkg::dim_t       K,
    input  tpu_pkg::dim_t       M,
    input  tpu_pkg::dim_t       N,
    input  tpu_pkg::lane_word_t A_data_out,
    input  tpu_pkg::lane_word_t B_data_out,
    output logic                busy,
    output tpu_pkg::index_t     A_index,
    output tpu_pkg::index_t     B_index,
    output logic                C_wr_en,
    output tpu_pkg::index_t     C_index,
    output tpu_pkg::c_row_t     C_data_in
);

    logic                feed_en;
    logic                clear;
    tpu_pkg::lane_word_t west_lanes;
    tpu_pkg::lane_word_t north_lanes;
    tpu_pkg::psum_grid_t psum_grid;

    drain_if drn_bus ();

    // tile walk, A/B addressing, drain requests
    tile_sequencer u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .K        (K),
        .M        (M),
        .N        (N),
        .busy     (busy),
        .a_index  (A_index),
        .b_index  (B_index),
        .feed_en  (feed_en),
        .clear    (clear),
        .drn      (drn_bus.seq)
    );

    operand_skewer u_skew (
        .clk         (clk),
        .rst_n       (rst_n),
        .feed_en     (feed_en),
        .a_word      (A_data_out),
        .b_word      (B_data_out),
        .west_lanes  (west_lanes),
        .north_lanes (north_lanes)
    );

    pe_array u_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (clear),
        .west_lanes  (west_lanes),
        .north_lanes (north_lanes),
        .psum_grid   (psum_grid)
    );

    // row-wise write into buffer C
    result_drain u_drain (
        .clk       (clk),
        .rst_n     (rst_n),
        .psum_grid (psum_grid),
        .c_wr_en   (C_wr_en),
        .c_index   (C_index),
        .c_data    (C_data_in),
        .drn       (drn_bus.drain)
    );

endmodule

//--- tpu_chk.sv
`timescale 1ns/1ps

module tpu_chk (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic c_wr_en,
    input logic req,
    input logic ack
);

    // number of assertion failures so far
    int assert_fails = 0;

    // C writes only happen inside a job
    a_wr_busy: assert property (@(posedge clk) disable iff (!rst_n) c_wr_en |-> busy)
        else begin
            assert_fails++;
            $error("C write while busy is low");
        end

    // and only while a drain request is open
    a_wr_req: assert property (@(posedge clk) disable iff (!rst_n) c_wr_en |-> req)
        else begin
            assert_fails++;
            $error("C write without a drain request");
        end

    a_ack_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
        else begin
            assert_fails++;
            $error("drain ack rose without req");
        end

    a_busy_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy)
        else begin
            assert_fails++;
            $error("busy high right after reset release");
        end

endmodule

bind tpu_top tpu_chk u_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .busy    (busy),
    .c_wr_en (C_wr_en),
    .req     (drn_bus.req),
    .ack     (drn_bus.ack)
);

//--- tpu_tb.sv
`timescale 1ns/1ps

module tpu_tb;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    tpu_pkg::dim_t       K;
    tpu_pkg::dim_t       M;
    tpu_pkg::dim_t       N;
    tpu_pkg::lane_word_t A_data_out;
    tpu_pkg::lane_word_t B_data_out;
    logic                busy;
    tpu_pkg::index_t     A_index;
    tpu_pkg::index_t     B_index;
    logic                C_wr_en;
    tpu_pkg::index_t     C_index;
    tpu_pkg::c_row_t     C_data_in;

    // buffer models and the matrices behind them
    tpu_pkg::lane_word_t a_mem [1024];
    tpu_pkg::lane_word_t b_mem [1024];
    tpu_pkg::c_row_t     c_mem [1024];
    tpu_pkg::index_t     c_cnt [1024];
    tpu_pkg::index_t     write_total;
    tpu_pkg::elem_t      a_el [64][64];
    tpu_pkg::elem_t      b_el [64][64];

    int cur_k, cur_m, cur_n;
    int errors, checks_run, err_mark, test_num, falls, cycle_cnt, timeout_limit;
    logic [31:0] rng_state;
    logic        busy_q;

    // one entry per test: dimensions K, M, N
    int    tk [5] = '{1, 5, 3, 40, 6};
    int    tm [5] = '{4, 8, 6, 4, 5};
    int    tn [5] = '{4, 8, 7, 4, 4};
    string test_names [5] = '{"outer product", "two by two tiles", "short M block",
                              "full scale sums", "ignored restart"};

    tpu_top uut (
        .clk (clk), .rst_n (rst_n), .in_valid (in_valid), .K (K), .M (M), .N (N),
        .A_data_out (A_data_out), .B_data_out (B_data_out), .busy (busy),
        .A_index (A_index), .B_index (B_index), .C_wr_en (C_wr_en),
        .C_index (C_index), .C_data_in (C_data_in)
    );

    always #4 clk = ~clk;

    // A/B read with one cycle latency, C counts every write
    always @(posedge clk) begin
        A_data_out <= (A_index < $size(a_mem)) ? a_mem[A_index] : '0;
        B_data_out <= (B_index < $size(b_mem)) ? b_mem[B_index] : '0;
        if (C_wr_en) begin
            write_total <= write_total + 1'b1;
            if (C_index < $size(c_mem)) begin
                c_mem[C_index] <= C_data_in;
                c_cnt[C_index] <= c_cnt[C_index] + 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        busy_q    <= busy;
        cycle_cnt <= cycle_cnt + 1;
        if (busy_q && !busy) begin
            falls <= falls + 1;
        end
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout: busy never fell");
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int ceil_blocks(input int d);
        return (d + tpu_pkg::ARRAY_DIM - 1) / tpu_pkg::ARRAY_DIM;
    endfunction

    // plain matrix product, columns past N come out zero
    function automatic tpu_pkg::c_row_t ref_c_row(input int nb, input int r);
        tpu_pkg::c_row_t row;
        tpu_pkg::acc_t   sum;
        int              col;
        row = '0;
        for (int j = 0; j < tpu_pkg::ARRAY_DIM; j++) begin
            col = nb * tpu_pkg::ARRAY_DIM + j;
            sum = '0;
            for (int k = 0; k < cur_k && col < cur_n; k++) begin
                sum = sum + tpu_pkg::acc_t'(a_el[r][k]) * tpu_pkg::acc_t'(b_el[k][col]);
            end
            row[tpu_pkg::ACC_W*(tpu_pkg::ARRAY_DIM-1-j) +: tpu_pkg::ACC_W] = sum;
        end
        return row;
    endfunction

    task automatic check_c_row(input tpu_pkg::index_t addr, input tpu_pkg::c_row_t exp,
                               input tpu_pkg::c_row_t act);
        checks_run++;
        if (act !== exp) begin
            errors++;
            $display("ERR C_data_in addr=%h exp=%h act=%h", addr, exp, act);
        end
    endtask

    task automatic check_count(input string what, input tpu_pkg::index_t exp,
                               input tpu_pkg::index_t act);
        checks_run++;
        if (act !== exp) begin
            errors++;
            $display("ERR C writes %s exp=%h act=%h", what, exp, act);
        end
    endtask

    task automatic expect_low(input string name, input logic act);
        checks_run++;
        if (act !== 1'b0) begin
            errors++;
            $display("ERR %s exp=%h act=%h", name, 1'b0, act);
        end
    endtask

    // unused words carry their own address so stray reads show up
    task automatic fill_buffers(input bit all_max);
        tpu_pkg::lane_word_t word;
        for (int i = 0; i < $size(a_mem); i++) begin
            a_mem[i] = {tpu_pkg::index_t'(i), ~tpu_pkg::index_t'(i)};
            b_mem[i] = {~tpu_pkg::index_t'(i), tpu_pkg::index_t'(i)};
            c_mem[i] = '0;
            c_cnt[i] = '0;
        end
        write_total = '0;
        for (int i = 0; i < 64; i++) begin
            for (int j = 0; j < 64; j++) begin
                rng_state = xorshift32(rng_state);
                a_el[i][j] = (i < cur_m && j < cur_k) ? (all_max ? 8'hff : rng_state[7:0]) : '0;
                b_el[i][j] = (i < cur_k && j < cur_n) ? (all_max ? 8'hff : rng_state[15:8]) : '0;
            end
        end
        for (int blk = 0; blk < ceil_blocks(cur_m); blk++) begin
            for (int k = 0; k < cur_k; k++) begin
                for (int i = 0; i < tpu_pkg::ARRAY_DIM; i++) begin
                    word[tpu_pkg::ELEM_W*(tpu_pkg::ARRAY_DIM-1-i) +: tpu_pkg::ELEM_W] =
                        a_el[blk*tpu_pkg::ARRAY_DIM + i][k];
                end
                a_mem[blk*cur_k + k] = word;
            end
        end
        for (int blk = 0; blk < ceil_blocks(cur_n); blk++) begin
            for (int k = 0; k < cur_k; k++) begin
                for (int i = 0; i < tpu_pkg::ARRAY_DIM; i++) begin
                    word[tpu_pkg::ELEM_W*(tpu_pkg::ARRAY_DIM-1-i) +: tpu_pkg::ELEM_W] =
                        b_el[k][blk*tpu_pkg::ARRAY_DIM + i];
                end
                b_mem[blk*cur_k + k] = word;
            end
        end
    endtask

    task automatic start_job(input int k, input int m, input int n, input bit all_max);
        cur_k = k;
        cur_m = m;
        cur_n = n;
        fill_buffers(all_max);
        @(posedge clk);
        // the previous job's fall has been counted by this edge
        falls    = 0;
        in_valid <= 1'b1;
        K        <= tpu_pkg::dim_t'(k);
        M        <= tpu_pkg::dim_t'(m);
        N        <= tpu_pkg::dim_t'(n);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // returns one edge after busy has fallen
    task automatic wait_done();
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
    endtask

    task automatic verify_job();
        tpu_pkg::index_t addr;
        check_count("total", tpu_pkg::index_t'(ceil_blocks(cur_n) * cur_m), write_total);
        for (int nb = 0; nb < ceil_blocks(cur_n); nb++) begin
            for (int r = 0; r < cur_m; r++) begin
                addr = tpu_pkg::index_t'(nb * cur_m + r);
                check_count($sformatf("addr %h", addr), tpu_pkg::index_t'(1), c_cnt[addr]);
                check_c_row(addr, ref_c_row(nb, r), c_mem[addr]);
            end
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d error(s)", test_num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        K          = '0;
        M          = '0;
        N          = '0;
        A_data_out = '0;
        B_data_out = '0;
        rng_state  = 32'd8;
        {errors, checks_run, err_mark, test_num, falls, cycle_cnt} = '0;
        write_total = '0;
        timeout_limit = 200;
        for (int t = 0; t < 5; t++) begin
            timeout_limit += ceil_blocks(tm[t]) * ceil_blocks(tn[t])
                           * (tk[t] + tpu_pkg::SETTLE_CYCLES + 10);
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        expect_low("busy", busy);
        expect_low("C_wr_en", C_wr_en);
        for (int t = 0; t < 5; t++) begin
            start_job(tk[t], tm[t], tn[t], t == 3);
            if (t == 4) begin
                // second start mid-job with other dimensions
                repeat (5) @(posedge clk);
                in_valid <= 1'b1;
                K        <= 8'd9;
                M        <= 8'd12;
                N        <= 8'd12;
                @(posedge clk);
                in_valid <= 1'b0;
            end
            wait_done();
            verify_job();
            if (t == 4) begin
                repeat (20) @(posedge clk);
                checks_run++;
                if (falls != 1 || busy !== 1'b0) begin
                    errors++;
                    $display("busy fell %0d times and is %b, expected one fall", falls, busy);
                end
            end
            report_test(test_names[t]);
        end
        if (uut.u_chk.assert_fails != 0) begin
            errors += uut.u_chk.assert_fails;
            $display("bound assertions failed %0d time(s)", uut.u_chk.assert_fails);
        end
        $display("tests %0d, checks %0d, errors %0d", test_num, checks_run, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
tpu_pkg.sv
drain_if.sv
mac_pe.sv
pe_array.sv
operand_skewer.sv
result_drain.sv
tile_sequencer.sv
tpu_top.sv
tpu_chk.sv
tpu_tb.sv
